// ==== all.f ====
common/usr_pkg.sv
hdl/axi4lite_ctrl.sv
hdl/reg_decode.sv
pwm/pwm_channel.sv
hdl/read_mux.sv
hdl/usr_logic.sv
test/tb_usr_logic.sv

// ==== common/usr_pkg.sv ====
// shared types, register map and firmware constants
// for the user logic block

package usr_pkg;

    // ----------------------------------------------------------------------
    // vector types
    // ----------------------------------------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [5:0]  word_addr_t;
    typedef logic [15:0] cnt_t;

    // one register access from the bus front end
    typedef struct packed {
        word_addr_t addr;
        data_t      wdata;
        logic       wr;
        logic       rd;
    } reg_bus_t;

    // write request into a single pwm channel
    typedef struct packed {
        logic period_we;
        logic duty_we;
        cnt_t wdata;
    } chan_wr_t;

    // readback of a single pwm channel
    typedef struct packed {
        cnt_t period;
        cnt_t duty;
    } chan_regs_t;

    typedef struct packed {
        data_t ctrl;
        data_t test0;
        data_t test1;
    } glob_regs_t;

    // ----------------------------------------------------------------------
    // register map, word indices
    // ----------------------------------------------------------------------
    localparam word_addr_t UREG_FIRMWARE_DATE = 6'd0;
    localparam word_addr_t UREG_FIRMWARE_TIME = 6'd1;
    localparam word_addr_t UREG_CTRL          = 6'd2;
    localparam word_addr_t UREG_TEST0         = 6'd3;
    localparam word_addr_t UREG_TEST1         = 6'd4;
    // channel n: period at base + 2n, duty at base + 2n + 1
    localparam word_addr_t UREG_CHAN_BASE     = 6'd8;

    // build identification, read only
    localparam data_t FIRMWARE_DATE = 32'h5a17_0c3e;
    localparam data_t FIRMWARE_TIME = 32'h0000_1d42;

endpackage

// ==== hdl/axi4lite_ctrl.sv ====
// axi4-lite slave front end
// turns bus transactions into register write and read strobes

`timescale 1ns/1ps

module axi4lite_ctrl (
    input  logic             s_axi_clk,
    input  logic             s_axi_resetn,

    // write address and data
    input  logic [31:0]      s_axi_awaddr,
    input  logic [2:0]       s_axi_awprot,
    output logic             s_axi_awready,
    input  logic             s_axi_awvalid,
    input  logic [31:0]      s_axi_wdata,
    input  logic [3:0]       s_axi_wstrb,
    input  logic             s_axi_wvalid,
    output logic             s_axi_wready,

    // write response
    output logic [1:0]       s_axi_bresp,
    output logic             s_axi_bvalid,
    input  logic             s_axi_bready,

    // read address and data
    input  logic [31:0]      s_axi_araddr,
    input  logic [2:0]       s_axi_arprot,
    output logic             s_axi_arready,
    input  logic             s_axi_arvalid,
    output logic [31:0]      s_axi_rdata,
    output logic             s_axi_rvalid,
    output logic [1:0]       s_axi_rresp,
    input  logic             s_axi_rready,

    // register side
    output usr_pkg::reg_bus_t bus,
    input  usr_pkg::data_t    rdata
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic wr_ack;
    logic rd_ack;
    logic bvalid_q;
    logic rvalid_q;
    logic wr_start;
    logic rd_start;

    // ----------------------------------------------------------------------
    // handshake
    // ----------------------------------------------------------------------

    // a write needs address and data together, and no response in flight
    assign wr_start = s_axi_awvalid & s_axi_wvalid & ~wr_ack & ~bvalid_q;

    // writes win a tie so the shared strobe bus never carries both
    assign rd_start = s_axi_arvalid & ~rd_ack & ~rvalid_q & ~wr_start;

    always_ff @(posedge s_axi_clk) begin
        if (!s_axi_resetn) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_start;
            rd_ack <= rd_start;
        end
    end

    // response flags, held until the master takes them
    always_ff @(posedge s_axi_clk) begin
        if (!s_axi_resetn) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_ack) begin
                bvalid_q <= 1'b1;
            end else if (s_axi_bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_ack) begin
                rvalid_q <= 1'b1;
            end else if (s_axi_rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // register strobes
    // ----------------------------------------------------------------------

    // word index from byte address bits 7..2
    assign bus.addr  = wr_ack ? s_axi_awaddr[7:2] : s_axi_araddr[7:2];
    assign bus.wdata = s_axi_wdata;
    assign bus.wr    = wr_ack;
    assign bus.rd    = rd_ack;

    assign s_axi_awready = wr_ack;
    assign s_axi_wready  = wr_ack;
    assign s_axi_arready = rd_ack;

    assign s_axi_bvalid = bvalid_q;
    assign s_axi_bresp  = RESP_OKAY;
    assign s_axi_rvalid = rvalid_q;
    assign s_axi_rresp  = RESP_OKAY;
    // read data is registered in the read mux on the arready cycle
    assign s_axi_rdata  = rdata;

endmodule

// ==== hdl/read_mux.sv ====
// registered read data selection over globals and pwm channels

`timescale 1ns/1ps

module read_mux #(
    parameter int NCH = 4
) (
    input  logic                            s_axi_clk,
    input  usr_pkg::reg_bus_t               bus,
    input  usr_pkg::glob_regs_t             globs,
    input  usr_pkg::chan_regs_t [NCH-1:0]   chans,
    output usr_pkg::data_t                  rdata
);

    usr_pkg::data_t sel;

    always_comb begin
        // unmapped words read as zero
        sel = '0;
        case (bus.addr)
            usr_pkg::UREG_FIRMWARE_DATE: sel = usr_pkg::FIRMWARE_DATE;
            usr_pkg::UREG_FIRMWARE_TIME: sel = usr_pkg::FIRMWARE_TIME;
            usr_pkg::UREG_CTRL:          sel = globs.ctrl;
            usr_pkg::UREG_TEST0:         sel = globs.test0;
            usr_pkg::UREG_TEST1:         sel = globs.test1;
            default: begin
            end
        endcase

        // channel words, zero extended
        for (int n = 0; n < NCH; n++) begin
            if (bus.addr == usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n)) begin
                sel = {16'h0000, chans[n].period};
            end
            if (bus.addr == usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n + 1)) begin
                sel = {16'h0000, chans[n].duty};
            end
        end
    end

    // captured on the arready cycle, presented with rvalid
    always_ff @(posedge s_axi_clk) begin
        if (bus.rd) begin
            rdata <= sel;
        end
    end

endmodule

// ==== hdl/reg_decode.sv ====
// global registers and write steering to the pwm channels

`timescale 1ns/1ps

module reg_decode #(
    parameter int NCH = 4
) (
    input  logic                            s_axi_clk,
    input  logic                            s_axi_resetn,
    input  usr_pkg::reg_bus_t               bus,
    output usr_pkg::glob_regs_t             globs,
    output usr_pkg::chan_wr_t [NCH-1:0]     chan_wr,
    output logic [NCH-1:0]                  chan_en
);

    // ----------------------------------------------------------------------
    // global registers
    // ----------------------------------------------------------------------
    always_ff @(posedge s_axi_clk) begin
        if (!s_axi_resetn) begin
            globs <= '0;
        end else if (bus.wr) begin
            case (bus.addr)
                usr_pkg::UREG_CTRL: begin
                    globs.ctrl <= bus.wdata;
                end
                usr_pkg::UREG_TEST0: begin
                    globs.test0 <= bus.wdata;
                end
                usr_pkg::UREG_TEST1: begin
                    globs.test1 <= bus.wdata;
                end
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // per channel write enables
    // ----------------------------------------------------------------------
    for (genvar n = 0; n < NCH; n++) begin : g_chan
        localparam usr_pkg::word_addr_t PERIOD_ADDR =
            usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n);
        localparam usr_pkg::word_addr_t DUTY_ADDR =
            usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n + 1);

        assign chan_wr[n].period_we = bus.wr && (bus.addr == PERIOD_ADDR);
        assign chan_wr[n].duty_we   = bus.wr && (bus.addr == DUTY_ADDR);
        // only the low half of the word is kept
        assign chan_wr[n].wdata     = bus.wdata[15:0];

        // channel n runs while ctrl bit n is set
        assign chan_en[n] = globs.ctrl[n];
    end

endmodule

// ==== hdl/usr_logic.sv ====
// top level of the user logic block
// axi4-lite front end, register decoder, pwm row and read mux

`timescale 1ns/1ps

module usr_logic #(
    parameter int NCH = 4
) (
    input  logic                s_axi_clk,
    input  logic                s_axi_resetn,

    input  logic [31:0]         s_axi_awaddr,
    input  logic [2:0]          s_axi_awprot,
    output logic                s_axi_awready,
    input  logic                s_axi_awvalid,
    input  logic [31:0]         s_axi_wdata,
    input  logic [3:0]          s_axi_wstrb,
    input  logic                s_axi_wvalid,
    output logic                s_axi_wready,
    output logic [1:0]          s_axi_bresp,
    output logic                s_axi_bvalid,
    input  logic                s_axi_bready,

    input  logic [31:0]         s_axi_araddr,
    input  logic [2:0]          s_axi_arprot,
    output logic                s_axi_arready,
    input  logic                s_axi_arvalid,
    output logic [31:0]         s_axi_rdata,
    output logic                s_axi_rvalid,
    output logic [1:0]          s_axi_rresp,
    input  logic                s_axi_rready,

    output logic                test_gpio,
    output usr_pkg::data_t      reg_ctrl,
    output logic [NCH-1:0]      pwm
);

    usr_pkg::reg_bus_t                  bus;
    usr_pkg::data_t                     rdata;
    usr_pkg::glob_regs_t                globs;
    usr_pkg::chan_wr_t   [NCH-1:0]      chan_wr;
    usr_pkg::chan_regs_t [NCH-1:0]      chan_regs;
    logic                [NCH-1:0]      chan_en;

    // ----------------------------------------------------------------------
    // bus side
    // ----------------------------------------------------------------------
    axi4lite_ctrl m_axi4lite (.*);

    reg_decode #(.NCH(NCH)) m_reg_decode (
        .s_axi_clk    (s_axi_clk),
        .s_axi_resetn (s_axi_resetn),
        .bus          (bus),
        .globs        (globs),
        .chan_wr      (chan_wr),
        .chan_en      (chan_en)
    );

    read_mux #(.NCH(NCH)) m_read_mux (
        .s_axi_clk (s_axi_clk),
        .bus       (bus),
        .globs     (globs),
        .chans     (chan_regs),
        .rdata     (rdata)
    );

    // ----------------------------------------------------------------------
    // pwm row
    // ----------------------------------------------------------------------
    for (genvar n = 0; n < NCH; n++) begin : g_pwm
        pwm_channel m_pwm (
            .s_axi_clk    (s_axi_clk),
            .s_axi_resetn (s_axi_resetn),
            .wr           (chan_wr[n]),
            .en           (chan_en[n]),
            .regs         (chan_regs[n]),
            .pwm          (pwm[n])
        );
    end

    assign test_gpio = globs.test0[0];
    assign reg_ctrl  = globs.ctrl;

endmodule

// ==== pwm/pwm_channel.sv ====
// one pwm channel: period and duty registers, counter, output

`timescale 1ns/1ps

module pwm_channel (
    input  logic                s_axi_clk,
    input  logic                s_axi_resetn,
    input  usr_pkg::chan_wr_t   wr,
    input  logic                en,
    output usr_pkg::chan_regs_t regs,
    output logic                pwm
);

    usr_pkg::cnt_t period_q;
    usr_pkg::cnt_t duty_q;
    // working copies, taken over at each wrap
    usr_pkg::cnt_t period_act;
    usr_pkg::cnt_t duty_act;
    usr_pkg::cnt_t cnt;
    logic          wrap;

    always_ff @(posedge s_axi_clk) begin
        if (!s_axi_resetn) begin
            period_q <= '0;
            duty_q   <= '0;
        end else begin
            if (wr.period_we) begin
                period_q <= wr.wdata;
            end
            if (wr.duty_we) begin
                duty_q <= wr.wdata;
            end
        end
    end

    assign wrap = (cnt >= period_act);

    // counter runs 0..period, so one cycle is period + 1 clocks
    always_ff @(posedge s_axi_clk) begin
        if (!s_axi_resetn) begin
            cnt        <= '0;
            period_act <= '0;
            duty_act   <= '0;
        end else if (!en || wrap) begin
            cnt        <= '0;
            period_act <= period_q;
            duty_act   <= duty_q;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign pwm          = en && (cnt < duty_act);
    assign regs.period  = period_q;
    assign regs.duty    = duty_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_usr_logic -o Vtb_usr_logic -f all.f

./obj_dir/Vtb_usr_logic > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// ==== test/tb_usr_logic.sv ====
// testbench for the user logic block
// axi4-lite driver tasks, protocol assertions and pwm duty measurement

`timescale 1ns/1ps

module tb_usr_logic;

    localparam int NCH       = 4;
    localparam int TIMEOUT   = 200;
    localparam int F_AWREADY = 0;
    localparam int F_ARREADY = 1;
    localparam int F_BVALID  = 2;
    localparam int F_RVALID  = 3;
    localparam int F_PWM0    = 4;

    logic s_axi_clk, s_axi_resetn;
    logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata, reg_ctrl;
    logic [2:0] s_axi_awprot, s_axi_arprot;
    logic [3:0] s_axi_wstrb;
    logic [1:0] s_axi_bresp, s_axi_rresp;
    logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic s_axi_rvalid, s_axi_rready, test_gpio;
    logic [NCH-1:0] pwm;

    int          value_errors, protocol_errors, timeouts, highs;
    logic [31:0] lfsr, ctrl_w, test0_w, test1_w, rd;
    logic [15:0] period_w [NCH];
    logic [15:0] duty_w [NCH];
    // words outside the register map
    logic [5:0]  unmapped_words [4] = '{6'd5, 6'd7, 6'd16, 6'd63};

    usr_logic #(.NCH(NCH)) uut (.*);

    always #20 s_axi_clk = ~s_axi_clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            value_errors++;
            $display("FAIL %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic protocol_fail(input string what);
        protocol_errors++;
        $display("protocol error at %0t: %s", $time, what);
    endtask

    // polls one flag on each rising edge until it is seen or time runs out
    task automatic wait_for_flag(input int which, input string what);
        int   n;
        logic hit;
        n = 0;
        hit = 1'b0;
        while (!hit && n < TIMEOUT) begin
            @(posedge s_axi_clk);
            n++;
            case (which)
                F_AWREADY: hit = s_axi_awready;
                F_ARREADY: hit = s_axi_arready;
                F_BVALID:  hit = s_axi_bvalid;
                F_RVALID:  hit = s_axi_rvalid;
                default:   hit = pwm[0];
            endcase
        end
        if (!hit) begin
            timeouts++;
            $display("timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    task automatic axi_write(input logic [5:0] word, input logic [31:0] data);
        s_axi_awaddr  <= {24'h0, word, 2'b00};
        s_axi_wdata   <= data;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        wait_for_flag(F_AWREADY, "write address ready");
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b1;
        wait_for_flag(F_BVALID, "write response");
        s_axi_bready  <= 1'b0;
    endtask

    task automatic axi_read(input logic [5:0] word, output logic [31:0] data);
        s_axi_araddr  <= {24'h0, word, 2'b00};
        s_axi_arvalid <= 1'b1;
        wait_for_flag(F_ARREADY, "read address ready");
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        wait_for_flag(F_RVALID, "read data");
        data = s_axi_rdata;
        s_axi_rready  <= 1'b0;
    endtask

    task automatic read_check(input logic [5:0] word, input logic [31:0] exp, input string what);
        logic [31:0] data;
        axi_read(word, data);
        check_value(data, exp, what);
    endtask

    // ----------------------------------------------------------------------
    // protocol rules
    // ----------------------------------------------------------------------
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid) else protocol_fail("bvalid dropped");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid) else protocol_fail("rvalid dropped");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        s_axi_awready == s_axi_wready) else protocol_fail("awready and wready apart");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        s_axi_awready |=> s_axi_bvalid) else protocol_fail("bvalid late after write");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        $rose(s_axi_bvalid) |-> $past(s_axi_awready)) else protocol_fail("bvalid without write");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        s_axi_arready |=> s_axi_rvalid) else protocol_fail("rvalid late after read");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        $rose(s_axi_rvalid) |-> $past(s_axi_arready)) else protocol_fail("rvalid without read");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        (s_axi_bresp == 2'b00) && (s_axi_rresp == 2'b00)) else protocol_fail("response not OKAY");
    assert property (@(posedge s_axi_clk) disable iff (!s_axi_resetn)
        (pwm & ~reg_ctrl[NCH-1:0]) == '0) else protocol_fail("pwm high on a disabled channel");

    initial begin
        lfsr = 32'he1be87fc;
        {value_errors, protocol_errors, timeouts} = '0;
        {s_axi_clk, s_axi_resetn, s_axi_awvalid, s_axi_wvalid, s_axi_bready} = '0;
        {s_axi_arvalid, s_axi_rready, s_axi_awprot, s_axi_arprot} = '0;
        {s_axi_awaddr, s_axi_wdata, s_axi_araddr} = '0;
        s_axi_wstrb = 4'hf;
        repeat (16) @(posedge s_axi_clk);
        s_axi_resetn <= 1'b1;
        @(posedge s_axi_clk);

        // reset state and read-only words
        check_value(reg_ctrl, 0, "reg_ctrl after reset");
        check_value({31'b0, test_gpio}, 0, "test_gpio after reset");
        check_value({28'b0, pwm}, 0, "pwm after reset");
        for (int w = 2; w <= 4; w++) begin
            read_check(usr_pkg::word_addr_t'(w), 0, "global register after reset");
        end
        for (int w = 8; w < 8 + 2 * NCH; w++) begin
            read_check(usr_pkg::word_addr_t'(w), 0, "channel register after reset");
        end
        read_check(usr_pkg::UREG_FIRMWARE_DATE, usr_pkg::FIRMWARE_DATE, "firmware date");
        read_check(usr_pkg::UREG_FIRMWARE_TIME, usr_pkg::FIRMWARE_TIME, "firmware time");
        foreach (unmapped_words[i]) begin
            read_check(unmapped_words[i], 0, "unmapped word");
        end

        // global registers
        ctrl_w  = rand_bits(32);
        test0_w = rand_bits(32);
        test1_w = rand_bits(32);
        axi_write(usr_pkg::UREG_CTRL, ctrl_w);
        axi_write(usr_pkg::UREG_TEST0, test0_w);
        axi_write(usr_pkg::UREG_TEST1, test1_w);
        read_check(usr_pkg::UREG_CTRL, ctrl_w, "ctrl readback");
        read_check(usr_pkg::UREG_TEST0, test0_w, "test0 readback");
        read_check(usr_pkg::UREG_TEST1, test1_w, "test1 readback");
        check_value(reg_ctrl, ctrl_w, "reg_ctrl output");
        check_value({31'b0, test_gpio}, {31'b0, test0_w[0]}, "test_gpio");
        axi_write(usr_pkg::UREG_TEST0, test0_w ^ 32'h1);
        check_value({31'b0, test_gpio}, {31'b0, ~test0_w[0]}, "test_gpio after toggle");
        axi_write(usr_pkg::UREG_CTRL, 0);

        // channel registers, all written before any is read
        for (int n = 0; n < NCH; n++) begin
            rd = rand_bits(32);
            period_w[n] = rd[15:0];
            axi_write(usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n), rd);
            rd = rand_bits(32);
            duty_w[n] = rd[15:0];
            axi_write(usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n + 1), rd);
        end
        for (int n = 0; n < NCH; n++) begin
            read_check(usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n),
                       {16'h0, period_w[n]}, "period");
            read_check(usr_pkg::word_addr_t'(usr_pkg::UREG_CHAN_BASE + 2 * n + 1),
                       {16'h0, duty_w[n]}, "duty");
        end

        // ----------------------------------------------------------------------
        // pwm waveform on channel 0
        // ----------------------------------------------------------------------
        axi_write(usr_pkg::UREG_CHAN_BASE, 9);
        axi_write(usr_pkg::UREG_CHAN_BASE + 6'd1, 3);
        axi_write(usr_pkg::UREG_CTRL, 1);
        wait_for_flag(F_PWM0, "pwm output");
        repeat (10) @(posedge s_axi_clk);
        // any 50 clock window holds five whole periods
        highs = 0;
        repeat (50) begin
            @(posedge s_axi_clk);
            highs = highs + int'(pwm[0]);
        end
        check_value(highs, 15, "pwm high clocks, duty 3 of 10");
        axi_write(usr_pkg::UREG_CHAN_BASE + 6'd1, 12);
        repeat (20) @(posedge s_axi_clk);
        highs = 0;
        repeat (30) begin
            @(posedge s_axi_clk);
            highs = highs + int'(pwm[0]);
        end
        check_value(highs, 30, "pwm high clocks, duty above period");
        axi_write(usr_pkg::UREG_CTRL, 0);
        highs = 0;
        repeat (20) begin
            @(posedge s_axi_clk);
            highs = highs + int'(pwm[0]);
        end
        check_value(highs, 0, "pwm high clocks, channel disabled");

        // ----------------------------------------------------------------------
        // back-pressure, second request queued behind a held response
        // ----------------------------------------------------------------------
        test0_w = rand_bits(32);
        test1_w = rand_bits(32);
        s_axi_awaddr  <= {24'h0, usr_pkg::UREG_TEST0, 2'b00};
        s_axi_wdata   <= test0_w;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        wait_for_flag(F_AWREADY, "first write address ready");
        s_axi_awaddr <= {24'h0, usr_pkg::UREG_TEST1, 2'b00};
        s_axi_wdata  <= test1_w;
        repeat (6) begin
            @(posedge s_axi_clk);
            assert (s_axi_bvalid && !s_axi_awready) else begin
                value_errors++;
                $display("FAIL %0t: write accepted while a response was held", $time);
            end
        end
        s_axi_bready <= 1'b1;
        wait_for_flag(F_BVALID, "first write response");
        s_axi_bready <= 1'b0;
        wait_for_flag(F_AWREADY, "second write address ready");
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b1;
        wait_for_flag(F_BVALID, "second write response");
        s_axi_bready <= 1'b0;

        s_axi_araddr  <= {24'h0, usr_pkg::UREG_TEST0, 2'b00};
        s_axi_arvalid <= 1'b1;
        wait_for_flag(F_ARREADY, "first read address ready");
        s_axi_araddr <= {24'h0, usr_pkg::UREG_TEST1, 2'b00};
        repeat (6) begin
            @(posedge s_axi_clk);
            assert (s_axi_rvalid && !s_axi_arready) else begin
                value_errors++;
                $display("FAIL %0t: read accepted while read data was held", $time);
            end
        end
        s_axi_rready <= 1'b1;
        wait_for_flag(F_RVALID, "first read data");
        check_value(s_axi_rdata, test0_w, "held read of test0");
        s_axi_rready <= 1'b0;
        wait_for_flag(F_ARREADY, "second read address ready");
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        wait_for_flag(F_RVALID, "second read data");
        check_value(s_axi_rdata, test1_w, "queued read of test1");
        s_axi_rready <= 1'b0;
        @(posedge s_axi_clk);

        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
